//--- hyper_defs.svh
// --------------------------------------------------
// bus widths and storage sizes of the block mover.
// --------------------------------------------------
`ifndef HYPER_DEFS_SVH
`define HYPER_DEFS_SVH

`define ADDR_W     12   // word address.
`define COUNT_W    6    // block length.
`define WORD_W     16
`define ROW_W      32   // one dram row, two words.
`define TAG_W      25   // ancillary tag.
`define LSAB_DEPTH 64   // words per section.
`define ROWS       2048 // rows per bank.

`endif

//--- hyper_pkg.sv
// --------------------------------------------------
// mover state and controller operation types.
// --------------------------------------------------
package hyper_pkg;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_RUN    = 2'd1,
		ST_REPORT = 2'd2  // finish up, then back to idle.
	} mover_state_e;

	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} mcu_op_e;

endpackage

//--- lsab_buffer.sv
// --------------------------------------------------
// four-section staging fifo, 16-bit words plus an
// interrupt flag each, with one tag per section.
// --------------------------------------------------
`timescale 1ns/1ns
`include "hyper_defs.svh"

module lsab_buffer (
	input  logic                      CLK,
	input  logic                      RST,
	input  logic                      push,
	input  logic [1:0]                push_section,
	input  logic [`WORD_W-1:0]        push_data,
	input  logic                      push_int,
	input  logic                      tag_we,
	input  logic [1:0]                tag_section,
	input  logic [`TAG_W-1:0]         tag_data,
	input  logic                      lsab_read,
	input  logic [1:0]                lsab_section,
	output logic [3:0]                lsab_stop,
	output logic [3:0]                lsab_int,
	output logic [3:0][`TAG_W-1:0]    lsab_ancill,
	output logic [`WORD_W-1:0]        lsab_data,
	output logic                      lsab_valid
);
	localparam int PTR_W = $clog2(`LSAB_DEPTH);

	logic [`WORD_W:0]    mem [4][`LSAB_DEPTH]; // {int, word}.
	logic [PTR_W:0]      wr_ptr [4];           // extra bit tells full from empty.
	logic [PTR_W:0]      rd_ptr [4];
	logic [`TAG_W-1:0]   tag [4];
	logic [3:0]          empty;
	logic [3:0]          full;
	logic                pop;
	logic                push_ok;

	always_comb
	begin
		for (int s = 0; s < 4; s++)
		begin
			empty[s] = (wr_ptr[s] == rd_ptr[s]);
			full[s] = (wr_ptr[s][PTR_W] != rd_ptr[s][PTR_W]) &&
				(wr_ptr[s][PTR_W-1:0] == rd_ptr[s][PTR_W-1:0]);
			lsab_int[s] = mem[s][rd_ptr[s][PTR_W-1:0]][`WORD_W]; // head word.
			lsab_ancill[s] = tag[s];
		end
	end

	assign lsab_stop = empty;
	assign pop = lsab_read && !empty[lsab_section];
	assign push_ok = push && !full[push_section]; // full section drops it.

	// ------------------------------------------------
	// pointers
	// ------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			for (int s = 0; s < 4; s++)
			begin
				wr_ptr[s] <= '0;
				rd_ptr[s] <= '0;
			end
			lsab_valid <= 1'b0;
		end
		else
		begin
			if (push_ok)
				wr_ptr[push_section] <= wr_ptr[push_section] + 1'b1;
			if (pop)
				rd_ptr[lsab_section] <= rd_ptr[lsab_section] + 1'b1;
			lsab_valid <= pop; // word follows one cycle later.
		end
	end

	// storage, tags and the popped word.
	always_ff @(posedge CLK)
	begin
		if (push_ok)
			mem[push_section][wr_ptr[push_section][PTR_W-1:0]] <= {push_int, push_data};
		if (tag_we)
			tag[tag_section] <= tag_data;
		if (pop)
			lsab_data <= mem[lsab_section][rd_ptr[lsab_section][PTR_W-1:0]][`WORD_W-1:0];
	end

endmodule

//--- hyper_mvblck_todram.sv
// --------------------------------------------------
// block-to-dram mover. drains one lsab section into
// dram rows and reports count, stop cause and tag.
// --------------------------------------------------
`timescale 1ns/1ns
`include "hyper_defs.svh"

module hyper_mvblck_todram
	import hyper_pkg::*;
(
	input  logic                      CLK,
	input  logic                      RST,
	input  logic [3:0]                lsab_stop,
	input  logic [3:0]                lsab_int,
	input  logic [3:0][`TAG_W-1:0]    lsab_ancill,
	output logic                      lsab_read,
	output logic [1:0]                lsab_section,
	input  logic [`ADDR_W-1:0]        wr_start,
	input  logic [`COUNT_W-1:0]       wr_count,
	input  logic [1:0]                wr_section,
	input  logic [1:0]                wr_bank,
	input  logic                      wr_issue,
	output logic [`COUNT_W-1:0]       wr_count_sent,
	output logic                      wr_working,
	output logic                      wr_irq,
	output logic                      wr_abrupt,
	output logic [`TAG_W-1:0]         wr_ancill,
	output logic [`ADDR_W-1:0]        coll_address,
	output logic [3:0]                we_array,
	output logic [1:0]                request_access
);
	mover_state_e          state;
	logic [`COUNT_W-1:0]   count_req;
	logic [`COUNT_W-1:0]   len_left;
	logic [`ADDR_W-1:0]    track_addr;
	logic [1:0]            bank;
	logic                  pop_prev;   // previous cycle popped.
	logic                  irq_last;   // flag of the last word taken.
	logic                  sel_stop;
	logic                  sel_int;
	logic [`TAG_W-1:0]     sel_ancill;
	logic                  read_more;
	logic                  go;
	logic                  trigger;

	assign sel_stop = lsab_stop[lsab_section];
	assign sel_int = lsab_int[lsab_section];
	assign sel_ancill = lsab_ancill[lsab_section];

	assign read_more = (len_left != '0);
	assign go = read_more && !sel_stop; // a word is popped this cycle.
	assign trigger = track_addr[0];     // odd word closes a pair.

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= ST_IDLE;
			count_req <= '0;
			len_left <= '0;
			track_addr <= '0;
			bank <= '0;
			pop_prev <= 1'b0;
			irq_last <= 1'b0;
			lsab_read <= 1'b0;
			lsab_section <= '0;
			wr_count_sent <= '0;
			wr_working <= 1'b0;
			wr_irq <= 1'b0;
			wr_abrupt <= 1'b0;
			wr_ancill <= '0;
			coll_address <= '0;
			we_array <= '0;
			request_access <= '0;
		end
		else
		begin
			wr_working <= (state != ST_IDLE); // one cycle behind busy.
			case (state)
				ST_IDLE:
				begin
					lsab_section <= wr_section;
					count_req <= wr_count;
					len_left <= wr_count;
					track_addr <= wr_start;
					bank <= wr_bank;
					pop_prev <= 1'b0;
					irq_last <= 1'b0;
					request_access <= '0;
					if (wr_issue)
					begin
						lsab_read <= (wr_count != '0);
						state <= ST_RUN;
					end
				end
				ST_RUN:
				begin
					if (go)
					begin
						track_addr <= track_addr + 1'b1;
						len_left <= len_left - 1'b1;
						lsab_read <= (len_left > 1);
						irq_last <= sel_int;
					end
					else
					begin
						// done or ran dry. latch the report.
						lsab_read <= 1'b0;
						state <= ST_REPORT;
						wr_count_sent <= count_req - len_left;
						wr_irq <= irq_last;
						wr_abrupt <= read_more;
						wr_ancill <= sel_ancill;
					end
					pop_prev <= go;

					if (trigger)
					begin
						we_array <= {go, go, pop_prev, pop_prev}; // odd half on top.
						coll_address <= {track_addr[`ADDR_W-1:1], 1'b0};
						request_access <= bank;
					end
					else
						request_access <= '0;
				end
				ST_REPORT:
				begin
					request_access <= '0;
					state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hyper_mvblck_fromdram.sv
// --------------------------------------------------
// dram-to-host mover. one word per granted cycle to
// the host read port.
// --------------------------------------------------
`timescale 1ns/1ns
`include "hyper_defs.svh"

module hyper_mvblck_fromdram
	import hyper_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RST,
	input  logic                  rd_issue,
	input  logic [`ADDR_W-1:0]    rd_start,
	input  logic [`COUNT_W-1:0]   rd_count,
	input  logic                  rd_bank,
	output logic                  rd_req,
	output logic [`ADDR_W-1:0]    rd_addr,
	output logic                  rd_bank_sel,
	input  logic                  rd_grant,
	input  logic [`WORD_W-1:0]    mem_rdata,
	output logic [`WORD_W-1:0]    rd_data,
	output logic                  rd_valid,
	output logic                  rd_busy
);
	mover_state_e          state;
	logic [`COUNT_W-1:0]   left;
	logic                  mem_valid; // word arriving from the controller.

	assign rd_req = (state == ST_RUN);
	assign rd_busy = (state != ST_IDLE);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= ST_IDLE;
			left <= '0;
			rd_addr <= '0;
			rd_bank_sel <= 1'b0;
			mem_valid <= 1'b0;
			rd_valid <= 1'b0;
		end
		else
		begin
			mem_valid <= rd_grant;
			rd_valid <= mem_valid;
			case (state)
				ST_IDLE:
					if (rd_issue)
					begin
						rd_addr <= rd_start;
						left <= rd_count;
						rd_bank_sel <= rd_bank;
						state <= (rd_count != '0) ? ST_RUN : ST_REPORT;
					end
				ST_RUN:
					if (rd_grant) // no grant, address holds.
					begin
						rd_addr <= rd_addr + 1'b1;
						left <= left - 1'b1;
						if (left == 1)
							state <= ST_REPORT;
					end
				ST_REPORT:
					if (!mem_valid)
						state <= ST_IDLE; // last word already out.
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// data stage
	// --------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (mem_valid)
			rd_data <= mem_rdata;
	end

endmodule

//--- hyper_mcu.sv
// --------------------------------------------------
// memory controller. fixed-priority arbiter, word
// pair collector and two lane-masked dram banks.
// --------------------------------------------------
`timescale 1ns/1ns
`include "hyper_defs.svh"

module hyper_mcu
	import hyper_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RST,
	input  logic [`WORD_W-1:0]    lsab_data,
	input  logic                  lsab_valid,
	input  logic                  wr_working,
	input  logic [`ADDR_W-1:0]    coll_address,
	input  logic [3:0]            we_array,
	input  logic [1:0]            request_access,
	input  logic                  rd_req,
	input  logic [`ADDR_W-1:0]    rd_addr,
	input  logic                  rd_bank_sel,
	output logic                  rd_grant,
	output logic [`WORD_W-1:0]    mem_rdata
);
	mcu_op_e                   op;
	logic [1:0][`WORD_W-1:0]   coll;     // collected words.
	logic                      toggle;   // next half to fill.
	logic [`ROW_W-1:0]         wr_row;
	logic [`ROW_W-1:0]         bank_mem [2][`ROWS];

	// ------------------------------------------------
	// arbiter
	// ------------------------------------------------
	always_comb
	begin
		if (request_access != 2'b00)
			op = OP_WRITE; // write mover never waits.
		else if (rd_req)
			op = OP_READ;
		else
			op = OP_NONE;
	end

	assign rd_grant = (op == OP_READ);

	// collector. odd word is still on lsab_data at the strobe.
	always_ff @(posedge CLK)
	begin
		if (!RST)
			toggle <= 1'b0;
		else if (!wr_working)
			toggle <= 1'b0;
		else if (lsab_valid)
			toggle <= ~toggle;
	end

	always_ff @(posedge CLK)
	begin
		if (lsab_valid)
			coll[toggle] <= lsab_data;
	end

	assign wr_row = {lsab_data, coll[~toggle]};

	// ------------------------------------------------
	// banks
	// ------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (op == OP_WRITE)
			for (int b = 0; b < 2; b++)
				if (request_access[b])
					for (int l = 0; l < 4; l++)
						if (we_array[l])
							bank_mem[b][coll_address[`ADDR_W-1:1]][l*8 +: 8] <=
								wr_row[l*8 +: 8];
	end

	always_ff @(posedge CLK)
	begin
		if (op == OP_READ)
		begin
			if (rd_addr[0])
				mem_rdata <= bank_mem[rd_bank_sel][rd_addr[`ADDR_W-1:1]][`ROW_W-1:`WORD_W];
			else
				mem_rdata <= bank_mem[rd_bank_sel][rd_addr[`ADDR_W-1:1]][`WORD_W-1:0];
		end
	end

endmodule

//--- hyper_mover_top.sv
// --------------------------------------------------
// top level. staging buffer, both movers and the
// memory controller.
// --------------------------------------------------
`timescale 1ns/1ns
`include "hyper_defs.svh"

module hyper_mover_top (
	input  logic                  CLK,
	input  logic                  RST,
	input  logic                  push,
	input  logic [1:0]            push_section,
	input  logic [`WORD_W-1:0]    push_data,
	input  logic                  push_int,
	input  logic                  tag_we,
	input  logic [1:0]            tag_section,
	input  logic [`TAG_W-1:0]     tag_data,
	input  logic                  wr_issue,
	input  logic [`ADDR_W-1:0]    wr_start,
	input  logic [`COUNT_W-1:0]   wr_count,
	input  logic [1:0]            wr_section,
	input  logic [1:0]            wr_bank,
	output logic [`COUNT_W-1:0]   wr_count_sent,
	output logic                  wr_working,
	output logic                  wr_irq,
	output logic                  wr_abrupt,
	output logic [`TAG_W-1:0]     wr_ancill,
	input  logic                  rd_issue,
	input  logic [`ADDR_W-1:0]    rd_start,
	input  logic [`COUNT_W-1:0]   rd_count,
	input  logic                  rd_bank,
	output logic [`WORD_W-1:0]    rd_data,
	output logic                  rd_valid,
	output logic                  rd_busy
);
	logic [3:0]               lsab_stop;
	logic [3:0]               lsab_int;
	logic [3:0][`TAG_W-1:0]   lsab_ancill;
	logic                     lsab_read;
	logic [1:0]               lsab_section;
	logic [`WORD_W-1:0]       lsab_data;
	logic                     lsab_valid;
	logic [`ADDR_W-1:0]       coll_address;
	logic [3:0]               we_array;
	logic [1:0]               request_access;
	logic                     rd_req;
	logic [`ADDR_W-1:0]       rd_addr;
	logic                     rd_bank_sel;
	logic                     rd_grant;
	logic [`WORD_W-1:0]       mem_rdata;

	lsab_buffer u_lsab (
		.CLK(CLK), .RST(RST),
		.push(push), .push_section(push_section),
		.push_data(push_data), .push_int(push_int),
		.tag_we(tag_we), .tag_section(tag_section), .tag_data(tag_data),
		.lsab_read(lsab_read), .lsab_section(lsab_section),
		.lsab_stop(lsab_stop), .lsab_int(lsab_int), .lsab_ancill(lsab_ancill),
		.lsab_data(lsab_data), .lsab_valid(lsab_valid)
	);

	hyper_mvblck_todram u_todram (
		.CLK(CLK), .RST(RST),
		.lsab_stop(lsab_stop), .lsab_int(lsab_int), .lsab_ancill(lsab_ancill),
		.lsab_read(lsab_read), .lsab_section(lsab_section),
		.wr_start(wr_start), .wr_count(wr_count), .wr_section(wr_section),
		.wr_bank(wr_bank), .wr_issue(wr_issue),
		.wr_count_sent(wr_count_sent), .wr_working(wr_working), .wr_irq(wr_irq),
		.wr_abrupt(wr_abrupt), .wr_ancill(wr_ancill),
		.coll_address(coll_address), .we_array(we_array),
		.request_access(request_access)
	);

	hyper_mvblck_fromdram u_fromdram (
		.CLK(CLK), .RST(RST),
		.rd_issue(rd_issue), .rd_start(rd_start), .rd_count(rd_count),
		.rd_bank(rd_bank),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_bank_sel(rd_bank_sel),
		.rd_grant(rd_grant), .mem_rdata(mem_rdata),
		.rd_data(rd_data), .rd_valid(rd_valid), .rd_busy(rd_busy)
	);

	hyper_mcu u_mcu (
		.CLK(CLK), .RST(RST),
		.lsab_data(lsab_data), .lsab_valid(lsab_valid), .wr_working(wr_working),
		.coll_address(coll_address), .we_array(we_array),
		.request_access(request_access),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_bank_sel(rd_bank_sel),
		.rd_grant(rd_grant), .mem_rdata(mem_rdata)
	);

endmodule

//--- tb_hyper_tasks.svh
// --------------------------------------------------
// host port drivers, bounded waits and the directed
// tests of the block mover testbench.
// --------------------------------------------------
`ifndef TB_HYPER_TASKS_SVH
`define TB_HYPER_TASKS_SVH

task automatic load_tag(input logic [1:0] section, input logic [`TAG_W-1:0] tag);
	@(posedge CLK);
	tag_we <= 1'b1;
	tag_section <= section;
	tag_data <= tag;
	@(posedge CLK);
	tag_we <= 1'b0;
endtask

task automatic push_words(input logic [1:0] section, input int n);
	logic [`WORD_W-1:0] w;
	logic f;
	staged_words.delete();
	staged_ints.delete();
	for (int i = 0; i < n; i++)
	begin
		w = `WORD_W'($random(seed));
		f = 1'($random(seed));
		@(posedge CLK);
		push <= 1'b1;
		push_section <= section;
		push_data <= w;
		push_int <= f;
		staged_words.push_back(w);
		staged_ints.push_back(f);
	end
	@(posedge CLK);
	push <= 1'b0;
endtask

task automatic issue_write(input logic [`ADDR_W-1:0] start, input int count,
	input logic [1:0] section, input logic [1:0] mask);
	@(posedge CLK);
	wr_issue <= 1'b1;
	wr_start <= start;
	wr_count <= `COUNT_W'(count);
	wr_section <= section;
	wr_bank <= mask;
	@(posedge CLK);
	wr_issue <= 1'b0;
endtask

// working rises one cycle after issue, its fall ends the block.
task automatic wait_write_done(input string name);
	int n;
	n = 0;
	while (wr_working !== 1'b1 && n < TIMEOUT)
	begin
		@(negedge CLK);
		n++;
	end
	if (wr_working !== 1'b1)
	begin
		errors++;
		$display("%s: write mover never started working", name);
	end
	else
	begin
		n = 0;
		while (wr_working !== 1'b0 && n < TIMEOUT)
		begin
			@(negedge CLK);
			n++;
		end
		if (wr_working !== 1'b0)
		begin
			errors++;
			$display("%s: write mover did not finish within %0d cycles", name, TIMEOUT);
		end
	end
endtask

task automatic read_block(input string name, input logic [`ADDR_W-1:0] start,
	input int count, input logic bank);
	int n;
	logic started;
	logic done;
	read_words.delete();
	@(posedge CLK);
	rd_issue <= 1'b1;
	rd_start <= start;
	rd_count <= `COUNT_W'(count);
	rd_bank <= bank;
	@(posedge CLK);
	rd_issue <= 1'b0;
	n = 0;
	started = 1'b0;
	done = 1'b0;
	while (!done && n < TIMEOUT)
	begin
		@(negedge CLK);
		if (rd_valid)
			read_words.push_back(rd_data);
		if (rd_busy)
			started = 1'b1;
		else if (started)
			done = 1'b1; // busy dropped after the last word.
		n++;
	end
	if (!done)
	begin
		errors++;
		$display("%s: read mover did not finish within %0d cycles", name, TIMEOUT);
	end
endtask

task automatic check_report(input string name, input int sent, input logic abrupt,
	input logic [`TAG_W-1:0] tag);
	check_value($sformatf("%s: count sent", name), 32'(sent), 32'(wr_count_sent));
	check_value($sformatf("%s: abrupt", name), 32'(abrupt), 32'(wr_abrupt));
	check_value($sformatf("%s: irq", name), 32'(staged_ints[sent - 1]), 32'(wr_irq));
	check_value($sformatf("%s: tag", name), 32'(tag), 32'(wr_ancill));
endtask

// tag, push, issue, wait, then check the report and track dram.
task automatic write_block(input string name, input logic [1:0] section,
	input logic [`ADDR_W-1:0] start, input int count, input int pushed,
	input logic [1:0] mask);
	logic [`TAG_W-1:0] tag;
	int sent;
	tag = `TAG_W'($random(seed));
	sent = expected_sent(count, pushed);
	load_tag(section, tag);
	push_words(section, pushed);
	issue_write(start, count, section, mask);
	wait_write_done(name);
	check_report(name, sent, pushed < count, tag);
	update_shadow(start, sent, mask);
endtask

// ------------------------------------------------
// directed tests
// ------------------------------------------------
task automatic check_reset_state();
	@(negedge CLK);
	check_value("reset: wr_working", 32'd0, 32'(wr_working));
	check_value("reset: wr_irq", 32'd0, 32'(wr_irq));
	check_value("reset: wr_abrupt", 32'd0, 32'(wr_abrupt));
	check_value("reset: rd_valid", 32'd0, 32'(rd_valid));
	check_value("reset: rd_busy", 32'd0, 32'(rd_busy));
	check_value("reset: wr_count_sent", 32'd0, 32'(wr_count_sent));
endtask

task automatic full_block();
	write_block("full block", 2'd1, 12'h020, 16, 16, 2'b01);
	read_block("full block", 12'h020, 16, 1'b0);
	compare_read("full block", 12'h020, 16, 1'b0);
endtask

task automatic early_stop();
	write_block("early stop", 2'd2, 12'h100, 12, 5, 2'b10); // section runs dry.
	read_block("early stop", 12'h100, 5, 1'b1);
	compare_read("early stop", 12'h100, 5, 1'b1);
endtask

// neighbours of the odd block keep the first fill.
task automatic odd_start_lanes();
	write_block("odd start fill", 2'd0, 12'h040, 10, 10, 2'b01);
	write_block("odd start", 2'd0, 12'h041, 7, 7, 2'b01);
	read_block("odd start", 12'h040, 10, 1'b0);
	compare_read("odd start", 12'h040, 10, 1'b0);
endtask

task automatic bank_mask();
	write_block("bank mask", 2'd3, 12'h200, 8, 8, 2'b11);
	read_block("bank mask", 12'h200, 8, 1'b0);
	compare_read("bank mask", 12'h200, 8, 1'b0);
	read_block("bank mask", 12'h200, 8, 1'b1);
	compare_read("bank mask", 12'h200, 8, 1'b1);
endtask

task automatic write_during_read();
	push_words(2'd1, 10);
	fork
		read_block("write during read", 12'h020, 16, 1'b0);
		begin
			repeat (3) @(posedge CLK);
			issue_write(12'h300, 10, 2'd1, 2'b01); // strobes steal read grants.
			wait_write_done("write during read");
		end
	join
	compare_read("write during read", 12'h020, 16, 1'b0);
	check_value("write during read: count sent", 32'(expected_sent(10, 10)),
		32'(wr_count_sent));
	update_shadow(12'h300, expected_sent(10, 10), 2'b01);
	read_block("write during read", 12'h300, 10, 1'b0);
	compare_read("write during read", 12'h300, 10, 1'b0);
endtask

`endif

//--- tb_hyper_mover.sv
// --------------------------------------------------
// testbench for the block mover. clock, reset, dut,
// shadow dram model and the closing report.
// --------------------------------------------------
`timescale 1ns/1ns
`include "hyper_defs.svh"

module tb_hyper_mover;
	localparam int TIMEOUT = 400; // cycles allowed per wait.

	logic                  CLK;
	logic                  RST;
	logic                  push;
	logic [1:0]            push_section;
	logic [`WORD_W-1:0]    push_data;
	logic                  push_int;
	logic                  tag_we;
	logic [1:0]            tag_section;
	logic [`TAG_W-1:0]     tag_data;
	logic                  wr_issue;
	logic [`ADDR_W-1:0]    wr_start;
	logic [`COUNT_W-1:0]   wr_count;
	logic [1:0]            wr_section;
	logic [1:0]            wr_bank;
	logic [`COUNT_W-1:0]   wr_count_sent;
	logic                  wr_working;
	logic                  wr_irq;
	logic                  wr_abrupt;
	logic [`TAG_W-1:0]     wr_ancill;
	logic                  rd_issue;
	logic [`ADDR_W-1:0]    rd_start;
	logic [`COUNT_W-1:0]   rd_count;
	logic                  rd_bank;
	logic [`WORD_W-1:0]    rd_data;
	logic                  rd_valid;
	logic                  rd_busy;

	integer                seed;
	int                    errors;
	int                    checks;
	logic [`WORD_W-1:0]    shadow [2][1 << `ADDR_W]; // word view of both banks.
	logic [`WORD_W-1:0]    staged_words [$];         // last words pushed.
	logic                  staged_ints [$];
	logic [`WORD_W-1:0]    read_words [$];

	hyper_mover_top dut (.*);

	initial
	begin
		CLK = 1'b0;
		forever
			#20 CLK = ~CLK;
	end

	// ------------------------------------------------
	// reference model
	// ------------------------------------------------
	// the mover stops at the request or when the section runs dry.
	function automatic int expected_sent(input int requested, input int pushed);
		return (pushed < requested) ? pushed : requested;
	endfunction

	task automatic update_shadow(input logic [`ADDR_W-1:0] start, input int sent,
		input logic [1:0] mask);
		logic [`ADDR_W-1:0] a;
		for (int i = 0; i < sent; i++)
		begin
			a = start + `ADDR_W'(i);
			for (int b = 0; b < 2; b++)
				if (mask[b])
					shadow[b][a] = staged_words[i]; // every masked bank.
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual == expected)
		else
		begin
			errors++;
			$display("** Error [%s] expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic compare_read(input string name, input logic [`ADDR_W-1:0] start,
		input int count, input logic bank);
		logic [`ADDR_W-1:0] a;
		check_value($sformatf("%s: words read", name), 32'(count),
			32'(read_words.size()));
		for (int i = 0; i < read_words.size(); i++)
		begin
			a = start + `ADDR_W'(i);
			check_value($sformatf("%s: bank %0d addr %0h", name, bank, a),
				32'(shadow[bank][a]), 32'(read_words[i]));
		end
	endtask

	`include "tb_hyper_tasks.svh"

	// ------------------------------------------------
	// test sequence
	// ------------------------------------------------
	initial
	begin
		seed = 32'h7f0a_740c;
		errors = 0;
		checks = 0;
		RST = 1'b0;
		push = 1'b0;
		push_section = '0;
		push_data = '0;
		push_int = 1'b0;
		tag_we = 1'b0;
		tag_section = '0;
		tag_data = '0;
		wr_issue = 1'b0;
		wr_start = '0;
		wr_count = '0;
		wr_section = '0;
		wr_bank = '0;
		rd_issue = 1'b0;
		rd_start = '0;
		rd_count = '0;
		rd_bank = 1'b0;
		repeat (2) @(posedge CLK);
		RST <= 1'b1;

		check_reset_state();
		full_block();
		early_stop();
		odd_start_lanes();
		bank_mask();
		write_during_read();

		repeat (2) @(posedge CLK);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- flist.f
+incdir+.
hyper_pkg.sv
lsab_buffer.sv
hyper_mvblck_todram.sv
hyper_mvblck_fromdram.sv
hyper_mcu.sv
hyper_mover_top.sv
tb_hyper_mover.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_hyper_mover -f flist.f -o tb_hyper_mover && \
	./obj_dir/tb_hyper_mover | tee /dev/stderr | grep -q "Done: no errors" && \
	echo "simulation passed" || { echo "simulation failed"; exit 1; }
